// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_csr_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: common.sv
`include "csr_macros.svh"

package common;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`CNT_W-1:0]      dword_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [`REG_IDX_W-1:0]  rd_idx_t;

    // implemented CSR addresses
    // counters sit at the machine counter addresses so they can be written
    typedef enum csr_addr_t {
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MEDELEG   = 12'h302,
        CSR_MIDELEG   = 12'h303,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MIP       = 12'h344,
        CSR_CYCLE     = 12'hb00,
        CSR_TIME      = 12'hb01,
        CSR_INSTRET   = 12'hb02,
        CSR_CYCLEH    = 12'hb80,
        CSR_TIMEH     = 12'hb81,
        CSR_INSTRETH  = 12'hb82,
        CSR_MVENDORID = 12'hf11,
        CSR_MARCHID   = 12'hf12,
        CSR_MIMPID    = 12'hf13,
        CSR_MHARTID   = 12'hf14
    } csr_t;

    // encoding follows funct3; 3'b100 has no operation
    typedef enum logic [2:0] {
        CSR_OP_NONE = 3'b000,
        CSR_OP_RW   = 3'b001,
        CSR_OP_RS   = 3'b010,
        CSR_OP_RC   = 3'b011,
        CSR_OP_RWI  = 3'b101,
        CSR_OP_RSI  = 3'b110,
        CSR_OP_RCI  = 3'b111
    } csr_op_t;

    // mstatus, msb first
    typedef struct packed {
        logic       sd;
        logic [7:0] reserved_23;
        logic       tsr;
        logic       tw;
        logic       tvm;
        logic       mxr;
        logic       sum;
        logic       mprv;
        logic [1:0] xs;
        logic [1:0] fs;
        logic [1:0] mpp;
        logic [1:0] reserved_9;
        logic       spp;
        logic       mpie;
        logic       reserved_6;
        logic       spie;
        logic       upie;
        logic       mie;
        logic       reserved_2;
        logic       sie;
        logic       uie;
    } status_t;

endpackage

// File: cpu_csr.sv
`timescale 1ns/1ns
`include "csr_macros.svh"

module cpu_csr
    import common::*;
(
    input  logic    clk_i,
    input  logic    reset_i,
    // an instruction retired this cycle
    input  logic    retired_i,
    csr_port_if.csr port
);

    // mstatus is fixed with mpie and spp set
    localparam status_t MSTATUS_RESET = '{
        mpie:    1'b1,
        spp:     1'b1,
        default: '0
    };

    word_t   mtvec_r;
    word_t   mie_r;
    word_t   mscratch_r;

    dword_t  cycle_r;
    dword_t  time_r;
    dword_t  instret_r;
    dword_t  cycle_w;
    dword_t  time_w;
    dword_t  instret_w;

    // counters advance unless a write replaces that half
    always_comb begin
        cycle_w   = cycle_r + 1'b1;
        time_w    = time_r + 1'b1;
        instret_w = instret_r + dword_t'(retired_i);

        if (port.write_enable) begin
            case (port.write_addr)
                CSR_CYCLE:    cycle_w[`XLEN-1:0]          = port.write_data;
                CSR_TIME:     time_w[`XLEN-1:0]           = port.write_data;
                CSR_INSTRET:  instret_w[`XLEN-1:0]        = port.write_data;
                CSR_CYCLEH:   cycle_w[`CNT_W-1:`XLEN]     = port.write_data;
                CSR_TIMEH:    time_w[`CNT_W-1:`XLEN]      = port.write_data;
                CSR_INSTRETH: instret_w[`CNT_W-1:`XLEN]   = port.write_data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cycle_r   <= '0;
            time_r    <= '0;
            instret_r <= '0;
        end else begin
            cycle_r   <= cycle_w;
            time_r    <= time_w;
            instret_r <= instret_w;
        end
    end

    // plain machine registers
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtvec_r    <= '0;
            mie_r      <= '0;
            mscratch_r <= '0;
        end else if (port.write_enable) begin
            case (port.write_addr)
                CSR_MTVEC:    mtvec_r    <= port.write_data & `MTVEC_MASK;
                CSR_MIE:      mie_r      <= port.write_data;
                CSR_MSCRATCH: mscratch_r <= port.write_data;
                default: ;
            endcase
        end
    end

    // registered read port
    always_ff @(posedge clk_i) begin
        if (reset_i || !port.read_enable) begin
            port.read_data <= '0;
        end else begin
            case (port.read_addr)
                CSR_MISA:      port.read_data <= `CSR_MISA_VAL;
                // non-commercial with no architecture id
                CSR_MVENDORID: port.read_data <= '0;
                CSR_MARCHID:   port.read_data <= '0;
                CSR_MIMPID:    port.read_data <= `CSR_MIMPID_VAL;
                // single hart
                CSR_MHARTID:   port.read_data <= '0;
                CSR_MSTATUS:   port.read_data <= MSTATUS_RESET;
                CSR_MTVEC:     port.read_data <= mtvec_r;
                // no delegation in machine-only core
                CSR_MEDELEG:   port.read_data <= '0;
                CSR_MIDELEG:   port.read_data <= '0;
                CSR_MIP:       port.read_data <= '0;
                CSR_MIE:       port.read_data <= mie_r;
                CSR_MSCRATCH:  port.read_data <= mscratch_r;
                CSR_CYCLE:     port.read_data <= cycle_r[`XLEN-1:0];
                CSR_TIME:      port.read_data <= time_r[`XLEN-1:0];
                CSR_INSTRET:   port.read_data <= instret_r[`XLEN-1:0];
                CSR_CYCLEH:    port.read_data <= cycle_r[`CNT_W-1:`XLEN];
                CSR_TIMEH:     port.read_data <= time_r[`CNT_W-1:`XLEN];
                CSR_INSTRETH:  port.read_data <= instret_r[`CNT_W-1:`XLEN];
                default:       port.read_data <= '0;
            endcase
        end
    end

endmodule

// File: csr_decode.sv
`timescale 1ns/1ns

module csr_decode
    import common::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       valid_i,
    input  logic [2:0] funct3_i,
    input  csr_t       addr_i,
    input  word_t      rs1_data_i,
    input  rd_idx_t    rs1_idx_i,
    input  rd_idx_t    rd_i,
    csr_req_if.dec     req
);

    csr_op_t   op_w;
    word_t     operand_w;
    csr_addr_t addr_bits;
    logic      known_w;
    logic      writes_w;
    logic      read_only_w;
    logic      illegal_w;

    always_comb begin
        case (funct3_i)
            3'b001:  op_w = CSR_OP_RW;
            3'b010:  op_w = CSR_OP_RS;
            3'b011:  op_w = CSR_OP_RC;
            3'b101:  op_w = CSR_OP_RWI;
            3'b110:  op_w = CSR_OP_RSI;
            3'b111:  op_w = CSR_OP_RCI;
            default: op_w = CSR_OP_NONE;
        endcase

        // immediate forms take zimm from the rs1 field
        operand_w = funct3_i[2] ? word_t'(rs1_idx_i) : rs1_data_i;

        // set and clear with x0 or zimm 0 only read
        case (op_w)
            CSR_OP_RW, CSR_OP_RWI: writes_w = 1'b1;
            CSR_OP_NONE:           writes_w = 1'b0;
            default:               writes_w = (rs1_idx_i != '0);
        endcase

        addr_bits = addr_i;
        known_w = addr_i inside {
            CSR_MSTATUS, CSR_MISA, CSR_MEDELEG, CSR_MIDELEG, CSR_MIE, CSR_MTVEC,
            CSR_MSCRATCH, CSR_MIP, CSR_CYCLE, CSR_TIME, CSR_INSTRET, CSR_CYCLEH,
            CSR_TIMEH, CSR_INSTRETH, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID,
            CSR_MHARTID
        };
        read_only_w = (addr_bits[11:10] == 2'b11);

        illegal_w = (op_w == CSR_OP_NONE) || !known_w || (writes_w && read_only_w);
    end

    // control state
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req.valid    <= 1'b0;
            req.write_en <= 1'b0;
            req.illegal  <= 1'b0;
        end else begin
            req.valid    <= valid_i;
            req.write_en <= valid_i && writes_w && !illegal_w;
            req.illegal  <= valid_i && illegal_w;
        end
    end

    // request payload
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            req.addr    <= addr_i;
            req.op      <= op_w;
            req.operand <= operand_w;
            req.rd      <= rd_i;
        end
    end

endmodule

// File: csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// data word and counter widths
`define XLEN        32
`define CNT_W       64
`define CSR_ADDR_W  12
`define REG_IDX_W   5

// misa: MXL=1 (32-bit), extensions A and I
`define CSR_MISA_VAL    32'h4000_0101

// implementation version 1
`define CSR_MIMPID_VAL  32'h0000_0001

// direct mode only, base aligned to 4 bytes
`define MTVEC_MASK      32'hffff_fffc

`endif

// File: csr_port_if.sv
`timescale 1ns/1ns

interface csr_port_if
    import common::*;
();

    // read port, data one cycle after enable
    csr_t  read_addr;
    logic  read_enable;
    word_t read_data;

    // write port, takes effect at the edge
    csr_t  write_addr;
    word_t write_data;
    logic  write_enable;

    modport wb (
        output read_addr, read_enable, write_addr, write_data, write_enable,
        input  read_data
    );

    modport csr (
        input  read_addr, read_enable, write_addr, write_data, write_enable,
        output read_data
    );

endinterface

// File: csr_req_if.sv
`timescale 1ns/1ns

interface csr_req_if
    import common::*;
();

    logic    valid;
    csr_t    addr;
    csr_op_t op;
    // rs1 value or zero-extended zimm
    word_t   operand;
    logic    write_en;
    logic    illegal;
    rd_idx_t rd;

    modport dec (
        output valid, addr, op, operand, write_en, illegal, rd
    );

    // read side of the register file
    modport csr (
        input valid, addr
    );

    modport wb (
        input valid, addr, op, operand, write_en, illegal, rd
    );

endinterface

// File: csr_top.sv
`timescale 1ns/1ns

module csr_top
    import common::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       retired_i,
    input  logic       req_valid_i,
    input  logic [2:0] req_funct3_i,
    input  csr_addr_t  req_addr_i,
    input  word_t      req_rs1_data_i,
    input  rd_idx_t    req_rs1_idx_i,
    input  rd_idx_t    req_rd_i,
    output logic       res_valid_o,
    output rd_idx_t    res_rd_o,
    output word_t      res_data_o,
    output logic       illegal_o
);

    csr_req_if  req_if ();
    csr_port_if port_if ();

    // unknown addresses pass through and are flagged by the decoder
    csr_decode csr_decode_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .valid_i    (req_valid_i),
        .funct3_i   (req_funct3_i),
        .addr_i     (csr_t'(req_addr_i)),
        .rs1_data_i (req_rs1_data_i),
        .rs1_idx_i  (req_rs1_idx_i),
        .rd_i       (req_rd_i),
        .req        (req_if.dec)
    );

    cpu_csr cpu_csr_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .retired_i  (retired_i),
        .port       (port_if.csr)
    );

    csr_writeback csr_writeback_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req         (req_if.wb),
        .port        (port_if.wb),
        .res_valid_o (res_valid_o),
        .res_rd_o    (res_rd_o),
        .res_data_o  (res_data_o),
        .illegal_o   (illegal_o)
    );

endmodule

// File: csr_writeback.sv
`timescale 1ns/1ns

module csr_writeback
    import common::*;
(
    input  logic    clk_i,
    input  logic    reset_i,
    csr_req_if.wb   req,
    csr_port_if.wb  port,
    output logic    res_valid_o,
    output rd_idx_t res_rd_o,
    output word_t   res_data_o,
    output logic    illegal_o
);

    logic    valid_q;
    logic    write_en_q;
    logic    illegal_q;
    csr_t    addr_q;
    csr_op_t op_q;
    word_t   operand_q;
    rd_idx_t rd_q;
    word_t   new_value;

    // read request goes straight to the register file
    assign port.read_addr   = req.addr;
    assign port.read_enable = req.valid;

    // request held one stage behind, in step with read_data
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q    <= 1'b0;
            write_en_q <= 1'b0;
            illegal_q  <= 1'b0;
        end else begin
            valid_q    <= req.valid;
            write_en_q <= req.write_en;
            illegal_q  <= req.illegal;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req.valid) begin
            addr_q    <= req.addr;
            op_q      <= req.op;
            operand_q <= req.operand;
            rd_q      <= req.rd;
        end
    end

    // read-modify-write
    always_comb begin
        case (op_q)
            CSR_OP_RW, CSR_OP_RWI: new_value = operand_q;
            CSR_OP_RS, CSR_OP_RSI: new_value = port.read_data | operand_q;
            CSR_OP_RC, CSR_OP_RCI: new_value = port.read_data & ~operand_q;
            default:               new_value = port.read_data;
        endcase
    end

    assign port.write_addr   = addr_q;
    assign port.write_data   = new_value;
    assign port.write_enable = write_en_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            res_valid_o <= 1'b0;
            illegal_o   <= 1'b0;
        end else begin
            res_valid_o <= valid_q && !illegal_q;
            illegal_o   <= valid_q && illegal_q;
        end
    end

    // old value is the rd result
    always_ff @(posedge clk_i) begin
        if (valid_q) begin
            res_rd_o   <= rd_q;
            res_data_o <= port.read_data;
        end
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset held for four rising edges
    initial begin
        reset_o = 1'b1;
        repeat (4) @(posedge clk_o);
        #1 reset_o = 1'b0;
    end

endmodule

// File: tb_csr_top.sv
`timescale 1ns/1ns
`include "csr_macros.svh"

module tb_csr_top
    import common::*;
();

    localparam logic [2:0] F3_RW  = 3'b001;
    localparam logic [2:0] F3_RS  = 3'b010;
    localparam logic [2:0] F3_RC  = 3'b011;
    localparam logic [2:0] F3_RWI = 3'b101;
    localparam logic [2:0] F3_RSI = 3'b110;
    localparam logic [2:0] F3_RCI = 3'b111;

    // reset and tests 1 to 6 at three cycles per access
    localparam int TEST_CYCLES    = 4 + 21 + 24 + 24 + 26 + 18 + 9;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 50;

    logic      clk;
    logic      reset;
    logic      retired;
    logic      req_valid;
    logic [2:0] req_funct3;
    csr_addr_t req_addr;
    word_t     req_rs1_data;
    rd_idx_t   req_rs1_idx;
    rd_idx_t   req_rd;
    logic      res_valid;
    rd_idx_t   res_rd;
    word_t     res_data;
    logic      illegal;

    int      errors = 0;
    int      checks = 0;
    int      cycle_count = 0;
    word_t   lfsr_state = 32'hec5c_1bf1;
    rd_idx_t rd_count = 5'd1;
    // expected contents of the writable CSRs
    word_t   m_mscratch = '0;
    word_t   m_mtvec = '0;
    word_t   m_mie = '0;

    tb_clock_gen tb_clock_gen_inst (.clk_o(clk), .reset_o(reset));

    csr_top csr_top_inst (
        .clk_i(clk), .reset_i(reset), .retired_i(retired),
        .req_valid_i(req_valid), .req_funct3_i(req_funct3), .req_addr_i(req_addr),
        .req_rs1_data_i(req_rs1_data), .req_rs1_idx_i(req_rs1_idx), .req_rd_i(req_rd),
        .res_valid_o(res_valid), .res_rd_o(res_rd), .res_data_o(res_data),
        .illegal_o(illegal)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic rand_word(output word_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    // one request with its result sampled in the cycle after edge E+2
    task automatic csr_access(input logic [2:0] f3, input csr_addr_t addr, input word_t data,
                              input rd_idx_t idx, input rd_idx_t rd, output word_t old,
                              output logic vld, output logic ill);
        req_valid    = 1'b1;
        req_funct3   = f3;
        req_addr     = addr;
        req_rs1_data = data;
        req_rs1_idx  = idx;
        req_rd       = rd;
        @(posedge clk);
        #1 req_valid = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        old = res_data;
        vld = res_valid;
        ill = illegal;
    endtask

    task automatic run_check(input logic [2:0] f3, input csr_addr_t addr, input word_t data,
                             input rd_idx_t idx, input word_t exp_old);
        word_t   old;
        logic    vld;
        logic    ill;
        rd_idx_t rd;
        rd = rd_count;
        rd_count = rd_count + 5'd1;
        csr_access(f3, addr, data, idx, rd, old, vld, ill);
        check_flag("res_valid_o", vld, 1'b1);
        check_flag("illegal_o", ill, 1'b0);
        check_word("res_rd_o", word_t'(res_rd), word_t'(rd));
        check_word("res_data_o", old, exp_old);
    endtask

    task automatic check_illegal(input logic [2:0] f3, input csr_addr_t addr, input word_t data);
        word_t old;
        logic  vld;
        logic  ill;
        csr_access(f3, addr, data, 5'd9, 5'd9, old, vld, ill);
        check_flag("illegal_o", ill, 1'b1);
        check_flag("res_valid_o", vld, 1'b0);
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - err_before);
    endtask

    task automatic test_reset_values();
        int      e0;
        status_t st;
        e0 = errors;
        st = '0;
        st.mpie = 1'b1;
        st.spp = 1'b1;
        run_check(F3_RS, CSR_MISA, 32'h0, 5'd0, `CSR_MISA_VAL);
        run_check(F3_RS, CSR_MIMPID, 32'h0, 5'd0, `CSR_MIMPID_VAL);
        run_check(F3_RS, CSR_MHARTID, 32'h0, 5'd0, 32'h0);
        run_check(F3_RS, CSR_MSTATUS, 32'h0, 5'd0, word_t'(st));
        run_check(F3_RS, CSR_MTVEC, 32'h0, 5'd0, 32'h0);
        run_check(F3_RS, CSR_MIE, 32'h0, 5'd0, 32'h0);
        run_check(F3_RS, CSR_MSCRATCH, 32'h0, 5'd0, 32'h0);
        finish_test("reset values", e0);
    endtask

    task automatic test_read_modify_write();
        int    e0;
        word_t v;
        e0 = errors;
        rand_word(v);
        run_check(F3_RW, CSR_MSCRATCH, v, 5'd1, m_mscratch);
        m_mscratch = v;
        for (int i = 0; i < 3; i++) begin
            rand_word(v);
            run_check(F3_RS, CSR_MSCRATCH, v, 5'd2, m_mscratch);
            m_mscratch = m_mscratch | v;
            rand_word(v);
            run_check(F3_RC, CSR_MSCRATCH, v, 5'd3, m_mscratch);
            m_mscratch = m_mscratch & ~v;
        end
        run_check(F3_RS, CSR_MSCRATCH, 32'h0, 5'd0, m_mscratch);
        finish_test("read-modify-write", e0);
    endtask

    task automatic test_immediate_forms();
        int    e0;
        word_t v;
        e0 = errors;
        // rs1 data must be ignored by the immediate forms
        run_check(F3_RWI, CSR_MSCRATCH, 32'hdead_beef, 5'h15, m_mscratch);
        m_mscratch = 32'h0000_0015;
        run_check(F3_RSI, CSR_MSCRATCH, 32'hffff_ffff, 5'd0, m_mscratch);
        run_check(F3_RCI, CSR_MSCRATCH, 32'hffff_ffff, 5'd0, m_mscratch);
        run_check(F3_RS, CSR_MSCRATCH, 32'h0, 5'd0, m_mscratch);
        // zimm 0 does not write, so a read-only CSR stays legal
        run_check(F3_RSI, CSR_MIMPID, 32'hffff_ffff, 5'd0, `CSR_MIMPID_VAL);
        run_check(F3_RCI, CSR_MIMPID, 32'hffff_ffff, 5'd0, `CSR_MIMPID_VAL);
        rand_word(v);
        run_check(F3_RW, CSR_MTVEC, v | 32'h3, 5'd4, m_mtvec);
        m_mtvec = v & ~32'h3;
        run_check(F3_RS, CSR_MTVEC, 32'h0, 5'd0, m_mtvec);
        finish_test("immediate forms", e0);
    endtask

    task automatic test_counters();
        int    e0;
        word_t c1;
        word_t c2;
        word_t v;
        logic  vld;
        logic  ill;
        e0 = errors;
        // second read sampled five edges after the first
        csr_access(F3_RS, CSR_CYCLE, 32'h0, 5'd0, 5'd1, c1, vld, ill);
        repeat (2) @(posedge clk);
        #1;
        csr_access(F3_RS, CSR_CYCLE, 32'h0, 5'd0, 5'd1, c2, vld, ill);
        check_word("cycle delta", c2 - c1, 32'd5);
        retired = 1'b1;
        repeat (6) @(posedge clk);
        #1 retired = 1'b0;
        run_check(F3_RS, CSR_INSTRET, 32'h0, 5'd0, 32'd6);
        // no carry into the high half while the low half is small
        csr_access(F3_RS, CSR_CYCLE, 32'h0, 5'd0, 5'd1, c1, vld, ill);
        check_flag("cycle low below carry", c1 < 32'hffff_ff00, 1'b1);
        rand_word(v);
        run_check(F3_RW, CSR_CYCLEH, v, 5'd5, 32'h0);
        run_check(F3_RS, CSR_CYCLEH, 32'h0, 5'd0, v);
        finish_test("counters", e0);
    endtask

    task automatic test_illegal();
        int    e0;
        word_t v;
        e0 = errors;
        rand_word(v);
        check_illegal(3'b000, CSR_MSCRATCH, v);
        run_check(F3_RS, CSR_MSCRATCH, 32'h0, 5'd0, m_mscratch);
        check_illegal(F3_RW, 12'h7c0, v);
        run_check(F3_RS, CSR_MSCRATCH, 32'h0, 5'd0, m_mscratch);
        check_illegal(F3_RW, CSR_MVENDORID, v);
        run_check(F3_RS, CSR_MVENDORID, 32'h0, 5'd0, 32'h0);
        finish_test("illegal requests", e0);
    endtask

    task automatic test_pipeline();
        int         e0;
        word_t      r1;
        word_t      r2;
        csr_addr_t  addrs[4];
        logic [2:0] f3s[4];
        word_t      data[4];
        word_t      exp[4];
        e0 = errors;
        rand_word(r1);
        rand_word(r2);
        addrs = '{CSR_MSCRATCH, CSR_MIE, CSR_MTVEC, CSR_MISA};
        f3s = '{F3_RS, F3_RW, F3_RW, F3_RS};
        data = '{32'h0, r1, r2, 32'h0};
        exp = '{m_mscratch, m_mie, m_mtvec, `CSR_MISA_VAL};
        // one request per cycle with results two edges later
        for (int cyc = 0; cyc < 6; cyc++) begin
            if (cyc < 4) begin
                req_valid    = 1'b1;
                req_funct3   = f3s[cyc];
                req_addr     = addrs[cyc];
                req_rs1_data = data[cyc];
                req_rs1_idx  = (f3s[cyc] == F3_RW) ? 5'd7 : 5'd0;
                req_rd       = rd_idx_t'(cyc + 10);
            end else begin
                req_valid = 1'b0;
            end
            @(posedge clk);
            #1;
            if (cyc >= 2) begin
                check_flag("res_valid_o", res_valid, 1'b1);
                check_word("res_rd_o", word_t'(res_rd), word_t'(cyc + 8));
                check_word("res_data_o", res_data, exp[cyc-2]);
            end
        end
        m_mie = r1;
        m_mtvec = r2 & ~32'h3;
        run_check(F3_RS, CSR_MTVEC, 32'h0, 5'd0, m_mtvec);
        finish_test("back-to-back pipeline", e0);
    endtask

    initial begin
        retired      = 1'b0;
        req_valid    = 1'b0;
        req_funct3   = 3'b000;
        req_addr     = '0;
        req_rs1_data = '0;
        req_rs1_idx  = '0;
        req_rd       = '0;
        @(negedge reset);
        test_reset_values();
        test_read_modify_write();
        test_immediate_forms();
        test_counters();
        test_illegal();
        test_pipeline();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
common.sv
csr_req_if.sv
csr_port_if.sv
csr_decode.sv
cpu_csr.sv
csr_writeback.sv
csr_top.sv
tb_clock_gen.sv
tb_csr_top.sv
